/* hdl/field_extract.sv */
module field_extract (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        s1_valid,
	input  thumb_dec_pkg::op_stage_t    s1,
	output logic                        s2_valid,
	output thumb_dec_pkg::field_stage_t s2
);

	localparam int RW = thumb_dec_pkg::RAW_IMM_W;

	logic [thumb_dec_pkg::HW_W-1:0] h0;
	logic [thumb_dec_pkg::HW_W-1:0] h1;
	logic                           s_bit;      // bl sign
	logic                           i1;
	logic                           i2;
	thumb_dec_pkg::field_stage_t    nxt;

	// low register field widened to a full index
	function automatic thumb_dec_pkg::reg_idx_t lo(input logic [2:0] f);
		return {1'b0, f};
	endfunction

	assign h0    = s1.ir.hw0;
	assign h1    = s1.ir.hw1;
	assign s_bit = h0[10];
	assign i1    = ~(h1[13] ^ s_bit);           // I1 = NOT(J1 EOR S)
	assign i2    = ~(h1[11] ^ s_bit);           // I2 = NOT(J2 EOR S)

	always_comb begin
		nxt     = '0;                           // undef and unused fields read zero
		nxt.cmd = s1.cmd;
		case (s1.cmd)
			thumb_dec_pkg::LSL_IMM5, thumb_dec_pkg::LSR_IMM5, thumb_dec_pkg::ASR_IMM5: begin
				nxt.rm       = lo(h0[5:3]);
				nxt.rd       = lo(h0[2:0]);
				nxt.imm_kind = thumb_dec_pkg::U5;
				nxt.imm_raw  = RW'(h0[10:6]);
			end
			thumb_dec_pkg::ADD_REG, thumb_dec_pkg::SUB_REG: begin
				nxt.rm = lo(h0[8:6]);
				nxt.rn = lo(h0[5:3]);
				nxt.rd = lo(h0[2:0]);
			end
			thumb_dec_pkg::ADD_IMM3, thumb_dec_pkg::SUB_IMM3: begin
				nxt.rn       = lo(h0[5:3]);
				nxt.rd       = lo(h0[2:0]);
				nxt.imm_kind = thumb_dec_pkg::U3;
				nxt.imm_raw  = RW'(h0[8:6]);
			end
			thumb_dec_pkg::MOV_IMM8, thumb_dec_pkg::CMP_IMM8,
			thumb_dec_pkg::ADD_IMM8, thumb_dec_pkg::SUB_IMM8: begin
				if (s1.cmd != thumb_dec_pkg::MOV_IMM8) nxt.rn = lo(h0[10:8]);
				if (s1.cmd != thumb_dec_pkg::CMP_IMM8) nxt.rd = lo(h0[10:8]);
				nxt.imm_kind = thumb_dec_pkg::U8;
				nxt.imm_raw  = RW'(h0[7:0]);
			end
			// rdn in bits 2:0, rm in 5:3
			thumb_dec_pkg::AND_REG, thumb_dec_pkg::EOR_REG, thumb_dec_pkg::ADC_REG,
			thumb_dec_pkg::SBC_REG, thumb_dec_pkg::ROR_REG, thumb_dec_pkg::ORR_REG,
			thumb_dec_pkg::BIC_REG: begin
				nxt.rm = lo(h0[5:3]);
				nxt.rn = lo(h0[2:0]);
				nxt.rd = lo(h0[2:0]);
			end
			thumb_dec_pkg::LSL_REG, thumb_dec_pkg::LSR_REG,
			thumb_dec_pkg::ASR_REG, thumb_dec_pkg::MUL_REG: begin
				nxt.rn = lo(h0[5:3]);           // rm and rn swapped
				nxt.rm = lo(h0[2:0]);
				nxt.rd = lo(h0[2:0]);
			end
			thumb_dec_pkg::TST_REG, thumb_dec_pkg::CMP_REG, thumb_dec_pkg::CMN_REG: begin
				nxt.rm = lo(h0[5:3]);           // compares write no rd
				nxt.rn = lo(h0[2:0]);
			end
			thumb_dec_pkg::RSB_IMM: begin
				nxt.rn = lo(h0[5:3]);           // rsbs rd, rn, #0
				nxt.rd = lo(h0[2:0]);
			end
			thumb_dec_pkg::MVN_REG: begin
				nxt.rm = lo(h0[5:3]);
				nxt.rd = lo(h0[2:0]);
			end
			thumb_dec_pkg::STR_REG, thumb_dec_pkg::STRH_REG, thumb_dec_pkg::STRB_REG,
			thumb_dec_pkg::LDRSB_REG, thumb_dec_pkg::LDR_REG, thumb_dec_pkg::LDRH_REG,
			thumb_dec_pkg::LDRB_REG, thumb_dec_pkg::LDRSH_REG: begin
				nxt.rm = lo(h0[8:6]);
				nxt.rn = lo(h0[5:3]);
				nxt.rt = lo(h0[2:0]);
			end
			thumb_dec_pkg::STR_IMM5, thumb_dec_pkg::LDR_IMM5,
			thumb_dec_pkg::STRB_IMM5, thumb_dec_pkg::LDRB_IMM5,
			thumb_dec_pkg::STRH_IMM5, thumb_dec_pkg::LDRH_IMM5: begin
				nxt.rn      = lo(h0[5:3]);
				nxt.rt      = lo(h0[2:0]);
				nxt.imm_raw = RW'(h0[10:6]);
				case (s1.cmd)                   // scale follows access size
					thumb_dec_pkg::STR_IMM5, thumb_dec_pkg::LDR_IMM5:
						nxt.imm_kind = thumb_dec_pkg::U5_X4;
					thumb_dec_pkg::STRH_IMM5, thumb_dec_pkg::LDRH_IMM5:
						nxt.imm_kind = thumb_dec_pkg::U5_X2;
					default:
						nxt.imm_kind = thumb_dec_pkg::U5;
				endcase
			end
			thumb_dec_pkg::LDR_LIT, thumb_dec_pkg::STR_SP, thumb_dec_pkg::LDR_SP: begin
				nxt.rt       = lo(h0[10:8]);
				nxt.imm_kind = thumb_dec_pkg::U8_X4;
				nxt.imm_raw  = RW'(h0[7:0]);
			end
			thumb_dec_pkg::ADR, thumb_dec_pkg::ADD_SP_IMM8: begin
				nxt.rd       = lo(h0[10:8]);
				nxt.imm_kind = thumb_dec_pkg::U8_X4;
				nxt.imm_raw  = RW'(h0[7:0]);
			end
			thumb_dec_pkg::B_COND: begin
				nxt.cond     = h0[11:8];
				nxt.imm_kind = thumb_dec_pkg::S8_BR;
				nxt.imm_raw  = RW'(h0[7:0]);
			end
			thumb_dec_pkg::B_UNCOND: begin
				nxt.imm_kind = thumb_dec_pkg::S11_BR;
				nxt.imm_raw  = RW'(h0[10:0]);
			end
			thumb_dec_pkg::BL: begin
				nxt.rd       = thumb_dec_pkg::REG_LR;  // return address lands in lr
				nxt.imm_kind = thumb_dec_pkg::BL_IMM;
				nxt.imm_raw  = {s_bit, i1, i2, h0[9:0], h1[10:0]};
			end
			default: nxt.cmd = thumb_dec_pkg::UNDEF;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			s2_valid <= 1'b0;
		end else begin
			s2_valid <= s1_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (s1_valid) begin
			s2 <= nxt;
		end
	end

endmodule

/* hdl/imm_expand.sv */
module imm_expand (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        s2_valid,
	input  thumb_dec_pkg::field_stage_t s2,
	output logic                        out_valid,
	output thumb_dec_pkg::dec_out_t     out_dec
);

	localparam int IW = thumb_dec_pkg::IMM_W;
	localparam int RW = thumb_dec_pkg::RAW_IMM_W;

	logic [RW-1:0] raw;
	logic [IW-1:0] imm;

	assign raw = s2.imm_raw;

	always_comb begin
		case (s2.imm_kind)
			thumb_dec_pkg::U3:     imm = IW'(raw[2:0]);
			thumb_dec_pkg::U5:     imm = IW'(raw[4:0]);
			thumb_dec_pkg::U5_X2:  imm = IW'({raw[4:0], 1'b0});   // halfword offset
			thumb_dec_pkg::U5_X4:  imm = IW'({raw[4:0], 2'b00});  // word offset
			thumb_dec_pkg::U8:     imm = IW'(raw[7:0]);
			thumb_dec_pkg::U8_X4:  imm = IW'({raw[7:0], 2'b00});
			// branch offsets are halfword units, sign taken from the top raw bit
			thumb_dec_pkg::S8_BR:  imm = {{(IW - 9){raw[7]}}, raw[7:0], 1'b0};
			thumb_dec_pkg::S11_BR: imm = {{(IW - 12){raw[10]}}, raw[10:0], 1'b0};
			thumb_dec_pkg::BL_IMM: imm = {{(IW - RW - 1){raw[RW-1]}}, raw, 1'b0};
			default:               imm = '0;    // no immediate
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= s2_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (s2_valid) begin
			out_dec.cmd  <= s2.cmd;
			out_dec.rm   <= s2.rm;
			out_dec.rn   <= s2.rn;
			out_dec.rd   <= s2.rd;
			out_dec.rt   <= s2.rt;
			out_dec.cond <= s2.cond;
			out_dec.imm  <= imm;
		end
	end

endmodule

/* hdl/ir_buffer.sv */
module ir_buffer #(
	parameter int IN_DEPTH    = 4,
	parameter int OUT_CREDITS = 4
) (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    in_valid,      // upstream only sends on a credit
	input  thumb_dec_pkg::ir_word_t in_word,
	input  logic                    credit_in,     // consumer frees one output slot
	output logic                    credit_return, // one credit back to fetch
	output logic                    issue,         // word enters stage 1 this cycle
	output thumb_dec_pkg::ir_word_t issue_word
);

	localparam int PTR_W = $clog2(IN_DEPTH);
	localparam int CNT_W = $clog2(IN_DEPTH + 1);
	localparam int CRD_W = $clog2(OUT_CREDITS + 1);

	thumb_dec_pkg::ir_word_t mem [IN_DEPTH];    // word queue storage

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] occ;                      // words held
	logic [CRD_W-1:0] credits;                  // output slots still free

	// pointer step with wrap, depth need not be a power of two
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(IN_DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign issue         = (occ != '0) && (credits != '0); // only issue point in the design
	assign credit_return = issue;               // popping frees an input slot
	assign issue_word    = mem[rd_ptr];         // head of queue

	always_ff @(posedge clk) begin
		if (in_valid) begin
			mem[wr_ptr] <= in_word;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			occ    <= '0;
		end else begin
			if (in_valid) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (issue) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			case ({in_valid, issue})
				2'b10:   occ <= occ + 1'b1;     // push only
				2'b01:   occ <= occ - 1'b1;     // pop only
				default: occ <= occ;            // both or neither
			endcase
		end
	end

	// output credit counter, one spent per issue and one back per credit_in
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			credits <= CRD_W'(OUT_CREDITS);
		end else begin
			case ({issue, credit_in})
				2'b10:   credits <= credits - 1'b1;
				2'b01:   credits <= credits + 1'b1;
				default: credits <= credits; // same cycle return cancels the spend
			endcase
		end
	end

endmodule

/* hdl/op_decode.sv */
module op_decode (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     issue,
	input  thumb_dec_pkg::ir_word_t  issue_word,
	output logic                     s1_valid,
	output thumb_dec_pkg::op_stage_t s1
);

	// instruction groups by hw0[15:10], dropped groups fold into GRP_NONE
	typedef enum logic [3:0] {
		GRP_NONE,
		GRP_BASIC,
		GRP_DP,
		GRP_LIT,
		GRP_LDST,
		GRP_ADR,
		GRP_SPADD,
		GRP_BCOND,
		GRP_B,
		GRP_WIDE
	} grp_e;

	logic [thumb_dec_pkg::HW_W-1:0] hw0;
	logic [thumb_dec_pkg::HW_W-1:0] hw1;
	logic                           is_wide;
	grp_e                           grp;
	thumb_dec_pkg::cmd_e            cmd;

	assign hw0 = issue_word.hw0;
	assign hw1 = issue_word.hw1;

	// 11101, 11110, 11111 start a 32-bit word, 11100 is still the 16-bit b
	assign is_wide = (hw0[15:13] == 3'b111) && (hw0[12:11] != 2'b00);

	always_comb begin
		grp = GRP_NONE;
		if (is_wide) begin
			grp = GRP_WIDE;
		end else begin
			casez (hw0[15:10])
				6'b00????: grp = GRP_BASIC;
				6'b010000: grp = GRP_DP;
				6'b01001?: grp = GRP_LIT;
				6'b0101??: grp = GRP_LDST;      // register offset
				6'b011???: grp = GRP_LDST;      // word and byte imm5
				6'b100???: grp = GRP_LDST;      // halfword imm5 and sp relative
				6'b10100?: grp = GRP_ADR;
				6'b10101?: grp = GRP_SPADD;
				6'b1101??: grp = GRP_BCOND;     // shares space with udf and svc
				6'b11100?: grp = GRP_B;
				default:   grp = GRP_NONE;      // special data/bx, misc, stm/ldm
			endcase
		end
	end

	always_comb begin
		cmd = thumb_dec_pkg::UNDEF;
		case (grp)
			GRP_BASIC: begin
				casez (hw0[13:9])
					5'b000??: cmd = thumb_dec_pkg::LSL_IMM5;
					5'b001??: cmd = thumb_dec_pkg::LSR_IMM5;
					5'b010??: cmd = thumb_dec_pkg::ASR_IMM5;
					5'b01100: cmd = thumb_dec_pkg::ADD_REG;
					5'b01101: cmd = thumb_dec_pkg::SUB_REG;
					5'b01110: cmd = thumb_dec_pkg::ADD_IMM3;
					5'b01111: cmd = thumb_dec_pkg::SUB_IMM3;
					5'b100??: cmd = thumb_dec_pkg::MOV_IMM8;
					5'b101??: cmd = thumb_dec_pkg::CMP_IMM8;
					5'b110??: cmd = thumb_dec_pkg::ADD_IMM8;
					default:  cmd = thumb_dec_pkg::SUB_IMM8;
				endcase
			end
			// opcode in bits 9:6 follows the enum order
			GRP_DP:    cmd = thumb_dec_pkg::cmd_e'(thumb_dec_pkg::AND_REG + hw0[9:6]);
			GRP_LIT:   cmd = thumb_dec_pkg::LDR_LIT;
			GRP_LDST: begin
				casez ({hw0[15:12], hw0[11:9]})     // {opA, opB}
					{4'b0101, 3'b???}: cmd = thumb_dec_pkg::cmd_e'(thumb_dec_pkg::STR_REG + hw0[11:9]);
					{4'b0110, 3'b0??}: cmd = thumb_dec_pkg::STR_IMM5;
					{4'b0110, 3'b1??}: cmd = thumb_dec_pkg::LDR_IMM5;
					{4'b0111, 3'b0??}: cmd = thumb_dec_pkg::STRB_IMM5;
					{4'b0111, 3'b1??}: cmd = thumb_dec_pkg::LDRB_IMM5;
					{4'b1000, 3'b0??}: cmd = thumb_dec_pkg::STRH_IMM5;
					{4'b1000, 3'b1??}: cmd = thumb_dec_pkg::LDRH_IMM5;
					{4'b1001, 3'b0??}: cmd = thumb_dec_pkg::STR_SP;
					default:           cmd = thumb_dec_pkg::LDR_SP;
				endcase
			end
			GRP_ADR:   cmd = thumb_dec_pkg::ADR;
			GRP_SPADD: cmd = thumb_dec_pkg::ADD_SP_IMM8;
			GRP_BCOND: begin
				if (hw0[11:9] != 3'b111) begin  // cond 1110 is udf, 1111 is svc
					cmd = thumb_dec_pkg::B_COND;
				end
			end
			GRP_B:     cmd = thumb_dec_pkg::B_UNCOND;
			GRP_WIDE: begin
				// bl: 11110 in hw0, 11x1 in hw1[15:12]
				if ((hw0[15:11] == 5'b11110) && (hw1[15:14] == 2'b11) && hw1[12]) begin
					cmd = thumb_dec_pkg::BL;
				end
			end
			default:   cmd = thumb_dec_pkg::UNDEF;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			s1_valid <= 1'b0;
		end else begin
			s1_valid <= issue;
		end
	end

	always_ff @(posedge clk) begin
		if (issue) begin
			s1.cmd <= cmd;                      // word travels with its command
			s1.ir  <= issue_word;
		end
	end

endmodule

/* hdl/thumb_dec_pkg.sv */
package thumb_dec_pkg;

	parameter int HW_W      = 16;              // one thumb halfword
	parameter int IMM_W     = 32;              // expanded immediate
	parameter int RAW_IMM_W = 24;              // widest raw field, bl S:I1:I2:imm10:imm11

	typedef logic [3:0] reg_idx_t;             // r0..r15
	typedef logic [3:0] cond_t;                // apsr condition code

	parameter reg_idx_t REG_LR = 4'd14;        // link register, target of bl

	// every kept command, UNDEF covers dropped and unallocated space
	typedef enum logic [5:0] {
		UNDEF       = 6'd0,
		// shift, add, subtract, move, compare
		LSL_IMM5,                              // lsls rd, rm, #imm5
		LSR_IMM5,
		ASR_IMM5,
		ADD_REG,                               // adds rd, rn, rm
		SUB_REG,
		ADD_IMM3,                              // adds rd, rn, #imm3
		SUB_IMM3,
		MOV_IMM8,
		CMP_IMM8,
		ADD_IMM8,                              // rdn form
		SUB_IMM8,
		// register data processing, ordered by opcode bits 9:6
		AND_REG, EOR_REG, LSL_REG, LSR_REG,
		ASR_REG, ADC_REG, SBC_REG, ROR_REG,
		TST_REG, RSB_IMM, CMP_REG, CMN_REG,
		ORR_REG, MUL_REG, BIC_REG, MVN_REG,
		LDR_LIT,                               // ldr rt, [pc, #imm8*4]
		// register offset load/store, ordered by opB
		STR_REG, STRH_REG, STRB_REG, LDRSB_REG,
		LDR_REG, LDRH_REG, LDRB_REG, LDRSH_REG,
		// immediate offset load/store
		STR_IMM5,                              // word, offset scaled by 4
		LDR_IMM5,
		STRB_IMM5,                             // byte, unscaled
		LDRB_IMM5,
		STRH_IMM5,                             // halfword, scaled by 2
		LDRH_IMM5,
		STR_SP,                                // sp relative, imm8*4
		LDR_SP,
		ADR,                                   // pc relative address
		ADD_SP_IMM8,                           // add rd, sp, #imm8*4
		B_COND,
		B_UNCOND,
		BL                                     // the only 32-bit command kept
	} cmd_e;

	// how stage 3 turns imm_raw into the 32-bit immediate
	typedef enum logic [3:0] {
		NONE   = 4'd0,                         // no immediate, result zero
		U3,                                    // zero extend 3 bits
		U5,                                    // zero extend 5 bits
		U5_X2,                                 // 5 bits, halfword scaled
		U5_X4,                                 // 5 bits, word scaled
		U8,
		U8_X4,
		S8_BR,                                 // b<c> offset, sign extended imm8:'0'
		S11_BR,                                // b offset, sign extended imm11:'0'
		BL_IMM                                 // S:I1:I2:imm10:imm11:'0'
	} imm_kind_e;

	typedef struct packed {
		logic [HW_W-1:0] hw0;                  // first halfword in program order
		logic [HW_W-1:0] hw1;                  // second halfword, only meaningful for wide words
	} ir_word_t;

	// stage 1 to stage 2
	typedef struct packed {
		cmd_e     cmd;
		ir_word_t ir;
	} op_stage_t;

	// stage 2 to stage 3
	typedef struct packed {
		cmd_e                 cmd;
		reg_idx_t             rm;
		reg_idx_t             rn;
		reg_idx_t             rd;
		reg_idx_t             rt;
		cond_t                cond;
		imm_kind_e            imm_kind;
		logic [RAW_IMM_W-1:0] imm_raw;         // right aligned raw bits
	} field_stage_t;

	// decoder output record
	typedef struct packed {
		cmd_e             cmd;
		reg_idx_t         rm;
		reg_idx_t         rn;
		reg_idx_t         rd;
		reg_idx_t         rt;
		cond_t            cond;
		logic [IMM_W-1:0] imm;
	} dec_out_t;

endpackage

/* hdl/thumb_dec_top.sv */
module thumb_dec_top #(
	parameter int IN_DEPTH    = 4,              // input queue depth, at least 2
	parameter int OUT_CREDITS = 4               // output credits after reset, at least 1
) (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    in_valid,
	input  thumb_dec_pkg::ir_word_t in_word,
	output logic                    credit_return,
	output logic                    out_valid,
	output thumb_dec_pkg::dec_out_t out_dec,
	input  logic                    credit_in
);

	logic                        issue;         // queue to stage 1
	thumb_dec_pkg::ir_word_t     issue_word;
	logic                        s1_valid;      // stage 1 to stage 2
	thumb_dec_pkg::op_stage_t    s1;
	logic                        s2_valid;      // stage 2 to stage 3
	thumb_dec_pkg::field_stage_t s2;

	ir_buffer #(
		.IN_DEPTH    (IN_DEPTH),
		.OUT_CREDITS (OUT_CREDITS)
	) u_ir_buffer (
		.clk           (clk),
		.rst_n         (rst_n),
		.in_valid      (in_valid),
		.in_word       (in_word),
		.credit_in     (credit_in),
		.credit_return (credit_return),
		.issue         (issue),
		.issue_word    (issue_word)
	);

	op_decode u_op_decode (
		.clk        (clk),
		.rst_n      (rst_n),
		.issue      (issue),
		.issue_word (issue_word),
		.s1_valid   (s1_valid),
		.s1         (s1)
	);

	field_extract u_field_extract (
		.clk      (clk),
		.rst_n    (rst_n),
		.s1_valid (s1_valid),
		.s1       (s1),
		.s2_valid (s2_valid),
		.s2       (s2)
	);

	// out_valid follows issue by three clocks
	imm_expand u_imm_expand (
		.clk       (clk),
		.rst_n     (rst_n),
		.s2_valid  (s2_valid),
		.s2        (s2),
		.out_valid (out_valid),
		.out_dec   (out_dec)
	);

endmodule

/* tests/dec_ref.svh */
`ifndef DEC_REF_SVH
`define DEC_REF_SVH

// random word patterns, hw0 = value | (random & ~mask)
localparam int PAT_N = 16;
localparam logic [15:0] PAT_VAL [PAT_N] = '{
	16'h0000, 16'h2000, 16'h4000, 16'h4800,    // shift/add/sub, imm8 ops, data proc, literal
	16'h5000, 16'h6000, 16'h8000, 16'hA000,    // ldst reg, word/byte imm5, half/sp, adr/sp add
	16'hD000, 16'hE000, 16'h4400, 16'hB000,    // b<c> with udf/svc, b, special data, misc
	16'hC000, 16'hE800, 16'hF000, 16'hF800     // stm/ldm, wide 11101, 11110, 11111
};
localparam logic [15:0] PAT_MASK [PAT_N] = '{
	16'hE000, 16'hE000, 16'hFC00, 16'hF800,
	16'hF000, 16'hE000, 16'hE000, 16'hF000,
	16'hF000, 16'hF800, 16'hFC00, 16'hF000,
	16'hF000, 16'hF800, 16'hF800, 16'hF800
};

// data processing commands by opcode bits 9:6
localparam thumb_dec_pkg::cmd_e DP_CMDS [16] = '{
	thumb_dec_pkg::AND_REG, thumb_dec_pkg::EOR_REG, thumb_dec_pkg::LSL_REG, thumb_dec_pkg::LSR_REG,
	thumb_dec_pkg::ASR_REG, thumb_dec_pkg::ADC_REG, thumb_dec_pkg::SBC_REG, thumb_dec_pkg::ROR_REG,
	thumb_dec_pkg::TST_REG, thumb_dec_pkg::RSB_IMM, thumb_dec_pkg::CMP_REG, thumb_dec_pkg::CMN_REG,
	thumb_dec_pkg::ORR_REG, thumb_dec_pkg::MUL_REG, thumb_dec_pkg::BIC_REG, thumb_dec_pkg::MVN_REG
};

// register offset load/store by opB
localparam thumb_dec_pkg::cmd_e LDST_REG_CMDS [8] = '{
	thumb_dec_pkg::STR_REG, thumb_dec_pkg::STRH_REG, thumb_dec_pkg::STRB_REG, thumb_dec_pkg::LDRSB_REG,
	thumb_dec_pkg::LDR_REG, thumb_dec_pkg::LDRH_REG, thumb_dec_pkg::LDRB_REG, thumb_dec_pkg::LDRSH_REG
};

function automatic thumb_dec_pkg::ir_word_t enc16(input logic [15:0] hw0);
	thumb_dec_pkg::ir_word_t w;
	w.hw0 = hw0;
	w.hw1 = 16'($urandom);                     // junk, a narrow word ignores it
	return w;
endfunction

function automatic thumb_dec_pkg::ir_word_t enc_bl(input logic s, j1, j2,
		input logic [9:0] imm10, input logic [10:0] imm11);
	thumb_dec_pkg::ir_word_t w;
	w.hw0 = {5'b11110, s, imm10};
	w.hw1 = {2'b11, j1, 1'b1, j2, imm11};
	return w;
endfunction

function automatic thumb_dec_pkg::ir_word_t rand_word(input int p);
	thumb_dec_pkg::ir_word_t w;
	w.hw0 = (16'($urandom) & ~PAT_MASK[p]) | PAT_VAL[p];
	w.hw1 = 16'($urandom);
	return w;
endfunction

// v holds a two's complement number of the given width
function automatic logic [31:0] sext(input logic [31:0] v, input int bits);
	logic [31:0] top;
	top = 32'd1 << (bits - 1);
	return (v ^ top) - top;
endfunction

function automatic thumb_dec_pkg::reg_idx_t low_reg(input logic [2:0] f);
	return {1'b0, f};
endfunction

function automatic thumb_dec_pkg::dec_out_t ref_decode(input thumb_dec_pkg::ir_word_t w);
	thumb_dec_pkg::dec_out_t d;
	logic [15:0] h;
	logic [15:0] g;
	logic [3:0]  op;
	logic        s;
	d  = '0;                                   // undef reads all zero
	h  = w.hw0;
	g  = w.hw1;
	op = h[9:6];
	s  = h[10];
	if (h[15:11] inside {5'b11101, 5'b11110, 5'b11111}) begin
		if (h[15:11] == 5'b11110 && g[15:14] == 2'b11 && g[12]) begin
			d.cmd = thumb_dec_pkg::BL;
			d.rd  = thumb_dec_pkg::REG_LR;
			d.imm = sext({s, ~(g[13] ^ s), ~(g[11] ^ s), h[9:0], g[10:0], 1'b0}, 25);
		end
		return d;
	end
	casez (h[15:11])
		5'b000??: begin
			d.rd = low_reg(h[2:0]);
			if (h[12:11] != 2'b11) begin            // shift by imm5
				d.cmd = (h[12:11] == 2'b00) ? thumb_dec_pkg::LSL_IMM5 :
					(h[12] ? thumb_dec_pkg::ASR_IMM5 : thumb_dec_pkg::LSR_IMM5);
				d.rm  = low_reg(h[5:3]);
				d.imm = 32'(h[10:6]);
			end else if (h[10]) begin              // imm3 add/sub
				d.cmd = h[9] ? thumb_dec_pkg::SUB_IMM3 : thumb_dec_pkg::ADD_IMM3;
				d.rn  = low_reg(h[5:3]);
				d.imm = 32'(h[8:6]);
			end else begin
				d.cmd = h[9] ? thumb_dec_pkg::SUB_REG : thumb_dec_pkg::ADD_REG;
				d.rn  = low_reg(h[5:3]);
				d.rm  = low_reg(h[8:6]);
			end
		end
		5'b001??: begin
			case (h[12:11])
				2'b00:   d.cmd = thumb_dec_pkg::MOV_IMM8;
				2'b01:   d.cmd = thumb_dec_pkg::CMP_IMM8;
				2'b10:   d.cmd = thumb_dec_pkg::ADD_IMM8;
				default: d.cmd = thumb_dec_pkg::SUB_IMM8;
			endcase
			if (h[12:11] != 2'b01) d.rd = low_reg(h[10:8]); // cmp writes nothing
			if (h[12:11] != 2'b00) d.rn = low_reg(h[10:8]); // mov reads nothing
			d.imm = 32'(h[7:0]);
		end
		5'b01000: begin
			if (!h[10]) begin                      // 010001 is special data, dropped
				d.cmd = DP_CMDS[op];
				if (!(op inside {4'd8, 4'd10, 4'd11})) d.rd = low_reg(h[2:0]);
				if (op inside {4'd2, 4'd3, 4'd4, 4'd13}) begin
					d.rm = low_reg(h[2:0]);        // shift amount or multiplier in rdn slot
					d.rn = low_reg(h[5:3]);
				end else if (op == 4'd9) begin
					d.rn = low_reg(h[5:3]);
				end else if (op == 4'd15) begin
					d.rm = low_reg(h[5:3]);
				end else begin
					d.rm = low_reg(h[5:3]);
					d.rn = low_reg(h[2:0]);
				end
			end
		end
		5'b01001: begin
			d.cmd = thumb_dec_pkg::LDR_LIT;
			d.rt  = low_reg(h[10:8]);
			d.imm = 32'(h[7:0]) * 4;
		end
		5'b0101?: begin
			d.cmd = LDST_REG_CMDS[h[11:9]];
			d.rm  = low_reg(h[8:6]);
			d.rn  = low_reg(h[5:3]);
			d.rt  = low_reg(h[2:0]);
		end
		5'b011??, 5'b1000?: begin
			d.rn = low_reg(h[5:3]);
			d.rt = low_reg(h[2:0]);
			if (h[15]) begin                       // halfword
				d.cmd = h[11] ? thumb_dec_pkg::LDRH_IMM5 : thumb_dec_pkg::STRH_IMM5;
				d.imm = 32'(h[10:6]) * 2;
			end else if (h[12]) begin              // byte
				d.cmd = h[11] ? thumb_dec_pkg::LDRB_IMM5 : thumb_dec_pkg::STRB_IMM5;
				d.imm = 32'(h[10:6]);
			end else begin
				d.cmd = h[11] ? thumb_dec_pkg::LDR_IMM5 : thumb_dec_pkg::STR_IMM5;
				d.imm = 32'(h[10:6]) * 4;
			end
		end
		5'b1001?: begin
			d.cmd = h[11] ? thumb_dec_pkg::LDR_SP : thumb_dec_pkg::STR_SP;
			d.rt  = low_reg(h[10:8]);
			d.imm = 32'(h[7:0]) * 4;
		end
		5'b1010?: begin
			d.cmd = h[11] ? thumb_dec_pkg::ADD_SP_IMM8 : thumb_dec_pkg::ADR;
			d.rd  = low_reg(h[10:8]);
			d.imm = 32'(h[7:0]) * 4;
		end
		5'b1101?: begin
			if (!(h[11:8] inside {4'hE, 4'hF})) begin // udf and svc stay undef
				d.cmd  = thumb_dec_pkg::B_COND;
				d.cond = h[11:8];
				d.imm  = sext(32'(h[7:0]) * 2, 9);
			end
		end
		5'b11100: begin
			d.cmd = thumb_dec_pkg::B_UNCOND;
			d.imm = sext(32'(h[10:0]) * 2, 12);
		end
		default: d = '0;                           // misc, stm/ldm
	endcase
	return d;
endfunction

`endif

/* tests/tb_thumb_dec.sv */
module tb_thumb_dec;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int IN_DEPTH    = 4;
	localparam int OUT_CREDITS = 4;
	localparam int N_RAND      = 12;             // random words per pattern

	logic                    clk;
	logic                    rst_n;
	logic                    in_valid;
	thumb_dec_pkg::ir_word_t in_word;
	logic                    credit_return;
	logic                    out_valid;
	thumb_dec_pkg::dec_out_t out_dec;
	logic                    credit_in;

	thumb_dec_pkg::ir_word_t stim [$];           // words in send order
	thumb_dec_pkg::dec_out_t exp_q [$];          // expected records with the oldest first
	bit stim_ready;
	bit run;
	int n_sent;
	int n_cmp;
	int n_ret;                                   // credit_return pulses seen
	int n_acc;                                   // outputs accepted by consumer
	int n_given;                                 // credit_in pulses applied
	int up_credits;
	int err_mis;
	int err_other;

	`include "dec_ref.svh"

	thumb_dec_top #(
		.IN_DEPTH    (IN_DEPTH),
		.OUT_CREDITS (OUT_CREDITS)
	) dut_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.in_valid      (in_valid),
		.in_word       (in_word),
		.credit_return (credit_return),
		.out_valid     (out_valid),
		.out_dec       (out_dec),
		.credit_in     (credit_in)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;                   // 4 ns period
	end

	task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
		if (got !== exp) begin
			err_mis++;
			$display("mismatch at %0t: %s got %0h expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic build_stim();
		int k;
		stim.push_back(enc16(16'h00D1));         // lsls r1, r2, #3
		stim.push_back(enc16(16'h1888));         // adds r0, r1, r2
		stim.push_back(enc16(16'h2AFF));         // cmp r2, #255
		stim.push_back(enc16(16'h4351));         // muls r1, r2
		stim.push_back(enc16(16'h6FFF));         // ldr r7, [r7, #124]
		stim.push_back(enc16(16'h8FFF));         // ldrh r7, [r7, #62]
		stim.push_back(enc16(16'hD0FE));         // beq back 4
		stim.push_back(enc16(16'hE7FE));         // b back 4
		stim.push_back(enc16(16'hDEFF));         // udf
		stim.push_back(enc16(16'hDF01));         // svc
		stim.push_back(enc16(16'hB580));         // push
		stim.push_back(enc16(16'h4770));         // bx lr
		stim.push_back(enc16(16'hC803));         // ldm
		stim.push_back('{hw0: 16'hF3EF, hw1: 16'h8000}); // mrs
		for (k = 0; k < 8; k++) begin            // every S, J1, J2 combination
			stim.push_back(enc_bl(k[2], k[1], k[0], 10'($urandom), 11'($urandom)));
		end
		stim.push_back(enc_bl(1'b1, 1'b1, 1'b1, 10'h3FF, 11'h7FF)); // bl back 2
		for (k = 0; k < PAT_N * N_RAND; k++) begin
			stim.push_back(rand_word(k % PAT_N));
		end
	endtask

	// upstream and consumer models drive on the falling edge
	initial begin
		int  cyc;
		int  phase;
		int  prob;
		int  hold_sent;
		bit  cr;
		bit  in_hold;
		cyc       = 0;
		hold_sent = 0;
		wait (run);
		forever begin
			@(negedge clk);
			cyc++;
			phase   = cyc % 80;
			in_hold = (phase >= 30) && (phase < 55); // consumer withholds credits
			cr      = credit_return;
			if (out_valid) n_acc++;
			if (credit_in) n_given++;            // reached the dut on the last edge
			if (cr) n_ret++;
			if (n_acc > OUT_CREDITS + n_given) begin
				err_other++;
				$display("at %0t more words came out than credits were given", $time);
			end
			if (phase == 30) hold_sent = 0;
			if (phase == 54) begin                 // hold long enough to drain everything
				check_eq(in_valid, 1'b0, "in_valid at end of credit hold");
				check_eq(cr, 1'b0, "credit_return at end of credit hold");
				if (hold_sent > IN_DEPTH + OUT_CREDITS) begin
					err_other++;
					$display("at %0t upstream kept sending during a credit hold", $time);
				end
			end
			// decide on credits held and bank this cycle's return afterwards
			if (up_credits > 0 && n_sent < stim.size() && $urandom_range(99) < 85) begin
				in_valid = 1'b1;
				in_word  = stim[n_sent];
				exp_q.push_back(ref_decode(stim[n_sent]));
				n_sent++;
				up_credits--;
				if (in_hold) hold_sent++;
			end else begin
				in_valid = 1'b0;
			end
			if (cr) up_credits++;
			if (up_credits < 0 || up_credits > IN_DEPTH) begin
				err_other++;
				$display("at %0t upstream credit count out of range: %0d", $time, up_credits);
			end
			prob = (phase < 30) ? 90 : (in_hold ? 0 : 30);
			credit_in = (n_acc > n_given) && ($urandom_range(99) < prob);
		end
	end

	always @(negedge clk) begin
		thumb_dec_pkg::dec_out_t e;
		if (out_valid) begin
			if (exp_q.size() == 0) begin
				err_other++;
				$display("at %0t an output appeared with no word outstanding", $time);
			end else begin
				e = exp_q.pop_front();
				check_eq(out_dec.cmd, e.cmd, $sformatf("word %0d cmd", n_cmp));
				check_eq(out_dec.rm, e.rm, $sformatf("word %0d rm", n_cmp));
				check_eq(out_dec.rn, e.rn, $sformatf("word %0d rn", n_cmp));
				check_eq(out_dec.rd, e.rd, $sformatf("word %0d rd", n_cmp));
				check_eq(out_dec.rt, e.rt, $sformatf("word %0d rt", n_cmp));
				check_eq(out_dec.cond, e.cond, $sformatf("word %0d cond", n_cmp));
				check_eq(out_dec.imm, e.imm, $sformatf("word %0d imm", n_cmp));
				n_cmp++;
			end
		end
	end

	// watchdog limit scales with the word count
	initial begin
		wait (stim_ready);
		#(stim.size() * 40 + 2000);
		$display("timeout: outputs still missing, %0d of %0d compared", n_cmp, stim.size());
		$display("errors: mismatch %0d other %0d", err_mis, err_other + 1);
		$display("sim failed");
		$finish;
	end

	initial begin
		void'($urandom(243));
		rst_n      = 1'b0;
		in_valid   = 1'b0;
		in_word    = '0;
		credit_in  = 1'b0;
		up_credits = IN_DEPTH;
		build_stim();
		stim_ready = 1'b1;
		repeat (4) begin
			@(negedge clk);
			check_eq(out_valid, 1'b0, "out_valid in reset");
			check_eq(credit_return, 1'b0, "credit_return in reset");
		end
		rst_n = 1'b1;
		@(negedge clk);
		check_eq(out_valid, 1'b0, "out_valid after reset");
		check_eq(credit_return, 1'b0, "credit_return after reset");
		run = 1'b1;
		wait (n_cmp == stim.size());
		repeat (20) @(negedge clk);              // room for stray outputs and late credits
		@(posedge clk);
		check_eq(n_ret, n_sent, "credit_return pulses against words sent");
		check_eq(up_credits, IN_DEPTH, "upstream credits after drain");
		$display("errors: mismatch %0d other %0d", err_mis, err_other);
		if (err_mis + err_other == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

/* thumb_dec_top.f */
+incdir+tests
hdl/thumb_dec_pkg.sv
hdl/ir_buffer.sv
hdl/op_decode.sv
hdl/field_extract.sv
hdl/imm_expand.sv
hdl/thumb_dec_top.sv
tests/tb_thumb_dec.sv
